// File: Makefile
# Verilator build and run of the I2C to Avalon-MM bridge testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_i2c_avl_bridge
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "run FAILED, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/avl_side_pkg.sv
/*
 * Types for the Avalon-MM master side: command and response bundles
 * plus byte-lane helpers shared by the packing and read-select logic.
 */

`include "bridge_consts.svh"

package avl_side_pkg;

	typedef struct packed {
		logic                   read;
		logic                   write;
		logic [`AVL_ADDR_W-1:0] addr;
		logic [`AVL_DATA_W-1:0] writedata;
		logic [`AVL_BE_W-1:0]   byteenable;
	} avl_cmd_t;

	typedef struct packed {
		logic                   waitrequest;
		logic                   readdatavalid;
		logic [`AVL_DATA_W-1:0] readdata;
	} avl_rsp_t;

	typedef logic [1:0] byte_lane_t;

	// byte enable bit for a single lane
	function automatic logic [`AVL_BE_W-1:0] lane_onehot(input byte_lane_t lane);
		return `AVL_BE_W'(1) << lane;
	endfunction

	function automatic logic [`I2C_BYTE_W-1:0] lane_byte(input logic [`AVL_DATA_W-1:0] word,
			input byte_lane_t lane);
		return word[lane * `I2C_BYTE_W +: `I2C_BYTE_W];
	endfunction

endpackage

// File: source/bridge_consts.svh
/*
 * Width and size constants for the I2C to Avalon-MM bridge.
 * Included by the packages and by every module that sizes a port or a counter.
 */

`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// word-address bytes sent by the master after the slave address, msb first
`define BRIDGE_ADDR_BYTES 2

`define I2C_BYTE_W 8
`define AVL_ADDR_W 32
`define AVL_DATA_W 32
`define AVL_BE_W   4

`define BYTE_ADDR_W (`I2C_BYTE_W * `BRIDGE_ADDR_BYTES) // byte-address counter

`endif

// File: source/bridge_fsm.sv
/*
 * Message sequencer for the bridge. Tracks the word-address phase, then
 * either the write packing phase or the read phase, and tells the address
 * counter and the lane steering block what to do on each I2C event.
 */

`timescale 1ns/1ps

`include "bridge_consts.svh"

module bridge_fsm
	import i2c_side_pkg::*;
(
	input  logic     i2c_clk,
	input  logic     i2c_rst_n,
	input  i2c_evt_t i2c_evt,
	input  logic     avl_readdatavalid,
	input  logic     word_full,
	input  logic     lanes_empty,
	input  logic     cmd_done,
	output logic     addr_shift,
	output logic     addr_load,
	output logic     pack_byte,
	output logic     issue_write,
	output logic     issue_read,
	output logic     rd_phase
);

	localparam int CNT_W = $clog2(`BRIDGE_ADDR_BYTES + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_ADDR_BYTE,
		ST_LOAD_ADDR,
		ST_WRITE_BYTE,
		ST_ISSUE_WRITE,
		ST_FLUSH_WRITE,
		ST_ISSUE_READ,
		ST_READ_BYTE
	} state_t;

	state_t           state;
	state_t           state_nxt;
	logic [CNT_W-1:0] addr_cnt;   // address bytes seen so far
	logic             ack_det_q;
	logic             bus_evt;
	logic             ack_rise;
	logic             last_addr;

	assign bus_evt   = i2c_evt.stop_det | i2c_evt.start_det;
	assign ack_rise  = i2c_evt.tx_chk_ack & i2c_evt.ack_det & ~ack_det_q;
	assign last_addr = (addr_cnt == CNT_W'(`BRIDGE_ADDR_BYTES - 1));

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (i2c_evt.rx_valid)
					state_nxt = (`BRIDGE_ADDR_BYTES == 1) ? ST_LOAD_ADDR : ST_ADDR_BYTE;
				else if (i2c_evt.rd_req)
					state_nxt = ST_ISSUE_READ; // current address read
			end
			ST_ADDR_BYTE: begin
				if (bus_evt)
					state_nxt = ST_IDLE; // counter left as it was
				else if (i2c_evt.rx_valid && last_addr)
					state_nxt = ST_LOAD_ADDR;
			end
			ST_LOAD_ADDR: state_nxt = ST_WRITE_BYTE;
			ST_WRITE_BYTE: begin
				if (bus_evt)
					state_nxt = lanes_empty ? ST_IDLE : ST_FLUSH_WRITE;
				else if (word_full)
					state_nxt = ST_ISSUE_WRITE;
			end
			ST_ISSUE_WRITE: if (cmd_done) state_nxt = ST_WRITE_BYTE;
			ST_FLUSH_WRITE: if (cmd_done) state_nxt = ST_IDLE;
			ST_ISSUE_READ:  if (cmd_done) state_nxt = ST_READ_BYTE;
			ST_READ_BYTE: begin
				if (bus_evt)
					state_nxt = ST_IDLE;
				else if (ack_rise)
					state_nxt = ST_ISSUE_READ; // master wants another byte
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			state      <= ST_IDLE;
			addr_cnt   <= '0;
			ack_det_q  <= 1'b0;
			addr_shift <= 1'b0;
			pack_byte  <= 1'b0;
		end else begin
			state     <= state_nxt;
			ack_det_q <= i2c_evt.ack_det;
			if (state == ST_IDLE && i2c_evt.rx_valid)
				addr_cnt <= CNT_W'(1);
			else if (state == ST_ADDR_BYTE && i2c_evt.rx_valid)
				addr_cnt <= addr_cnt + 1'b1;
			// byte pulses trail the rx strobe by one cycle
			addr_shift <= i2c_evt.rx_valid &
				((state == ST_IDLE) | ((state == ST_ADDR_BYTE) & ~bus_evt));
			pack_byte  <= i2c_evt.rx_valid & (state == ST_WRITE_BYTE) & ~bus_evt;
		end
	end

	assign addr_load   = (state == ST_LOAD_ADDR);
	assign issue_write = (state == ST_ISSUE_WRITE) | (state == ST_FLUSH_WRITE);
	assign issue_read  = (state == ST_ISSUE_READ);
	assign rd_phase    = (state == ST_READ_BYTE);

	// read data only comes back after a read was accepted in ST_ISSUE_READ
	a_rdv_in_read: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		avl_readdatavalid |-> rd_phase);

endmodule

// File: source/byte_lane_steer.sv
/*
 * Byte-lane datapath and Avalon command driver. Packs write bytes into a
 * 32-bit word with byte enables, holds read/write until waitrequest drops,
 * and picks the addressed byte out of returned read data.
 */

`timescale 1ns/1ps

`include "bridge_consts.svh"

module byte_lane_steer
	import i2c_side_pkg::*;
	import avl_side_pkg::*;
(
	input  logic                    i2c_clk,
	input  logic                    i2c_rst_n,
	input  logic [`I2C_BYTE_W-1:0]  rx_byte,
	input  logic                    pack_byte,
	input  logic                    issue_write,
	input  logic                    issue_read,
	input  logic                    rd_phase,
	input  logic [`BYTE_ADDR_W-1:0] byte_addr,
	input  avl_rsp_t                avl_rsp,
	output avl_cmd_t                avl_cmd,
	output rd_byte_t                rd_byte,
	output logic                    word_full,
	output logic                    lanes_empty,
	output logic                    cmd_done
);

	localparam int WADDR_W = `BYTE_ADDR_W - 2;
	localparam int PAD_W   = `AVL_ADDR_W - `BYTE_ADDR_W;

	byte_lane_t              lane;
	logic [`AVL_DATA_W-1:0]  wdata_q;
	logic [`AVL_BE_W-1:0]    be_q;
	logic [WADDR_W-1:0]      waddr_q;  // word being packed
	logic                    wr_q;
	logic                    rd_q;
	logic                    rd_valid_q;
	logic [`I2C_BYTE_W-1:0]  rd_data_q;
	logic                    rd_take;

	assign lane        = byte_addr[1:0];
	assign word_full   = pack_byte & (lane == 2'd3);
	assign lanes_empty = (be_q == '0) & ~pack_byte;
	assign cmd_done    = (wr_q | rd_q) & ~avl_rsp.waitrequest;
	assign rd_take     = avl_rsp.readdatavalid & rd_phase;

	always_ff @(posedge i2c_clk) begin
		if (pack_byte) begin
			wdata_q[lane * `I2C_BYTE_W +: `I2C_BYTE_W] <= rx_byte;
			if (be_q == '0)
				waddr_q <= byte_addr[`BYTE_ADDR_W-1:2]; // first byte of the word
		end
		if (rd_take)
			rd_data_q <= lane_byte(avl_rsp.readdata, lane);
	end

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n) begin
			be_q       <= '0;
			wr_q       <= 1'b0;
			rd_q       <= 1'b0;
			rd_valid_q <= 1'b0;
		end else begin
			if (wr_q && cmd_done)
				be_q <= '0;
			else if (pack_byte)
				be_q <= be_q | lane_onehot(lane);
			if (cmd_done) begin
				wr_q <= 1'b0;
				rd_q <= 1'b0;
			end else begin
				if (issue_write)
					wr_q <= 1'b1;
				if (issue_read)
					rd_q <= 1'b1;
			end
			rd_valid_q <= rd_take;
		end
	end

	// payload comes straight from registers that stay still while a command waits
	assign avl_cmd.read       = rd_q;
	assign avl_cmd.write      = wr_q;
	assign avl_cmd.addr       = rd_q ? {{PAD_W{1'b0}}, byte_addr[`BYTE_ADDR_W-1:2], 2'b00}
	                                 : {{PAD_W{1'b0}}, waddr_q, 2'b00};
	assign avl_cmd.writedata  = wdata_q;
	assign avl_cmd.byteenable = rd_q ? {`AVL_BE_W{1'b1}} : be_q;

	assign rd_byte = '{valid: rd_valid_q, data: rd_data_q};

	a_one_cmd: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		!(avl_cmd.read && avl_cmd.write));

	// a flush only issues when some lane was packed
	a_write_be: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		avl_cmd.write |-> (avl_cmd.byteenable != '0));

endmodule

// File: source/i2c_avl_bridge.sv
/*
 * Top of the I2C slave to Avalon-MM master message engine.
 * Connect i2c_evt to the slave core, avl_cmd/avl_rsp to the Avalon slave;
 * rx_byte is expected to hold its value after rx_valid until the next byte.
 */

`timescale 1ns/1ps

`include "bridge_consts.svh"

module i2c_avl_bridge
	import i2c_side_pkg::*;
	import avl_side_pkg::*;
(
	input  logic     i2c_clk,
	input  logic     i2c_rst_n,
	input  i2c_evt_t i2c_evt,
	input  avl_rsp_t avl_rsp,
	output avl_cmd_t avl_cmd,
	output rd_byte_t rd_byte
);

	logic                    addr_shift;
	logic                    addr_load;
	logic                    pack_byte;
	logic                    issue_write;
	logic                    issue_read;
	logic                    rd_phase;
	logic                    word_full;
	logic                    lanes_empty;
	logic                    cmd_done;
	logic [`BYTE_ADDR_W-1:0] byte_addr;

	bridge_fsm bridge_fsm_inst (
		.i2c_clk           (i2c_clk),
		.i2c_rst_n         (i2c_rst_n),
		.i2c_evt           (i2c_evt),
		.avl_readdatavalid (avl_rsp.readdatavalid),
		.word_full         (word_full),
		.lanes_empty       (lanes_empty),
		.cmd_done          (cmd_done),
		.addr_shift        (addr_shift),
		.addr_load         (addr_load),
		.pack_byte         (pack_byte),
		.issue_write       (issue_write),
		.issue_read        (issue_read),
		.rd_phase          (rd_phase)
	);

	word_addr_gen word_addr_gen_inst (
		.i2c_clk           (i2c_clk),
		.i2c_rst_n         (i2c_rst_n),
		.rx_byte           (i2c_evt.rx_byte),
		.addr_shift        (addr_shift),
		.addr_load         (addr_load),
		.pack_byte         (pack_byte),
		.avl_readdatavalid (avl_rsp.readdatavalid),
		.rd_phase          (rd_phase),
		.byte_addr         (byte_addr)
	);

	byte_lane_steer byte_lane_steer_inst (
		.i2c_clk     (i2c_clk),
		.i2c_rst_n   (i2c_rst_n),
		.rx_byte     (i2c_evt.rx_byte),
		.pack_byte   (pack_byte),
		.issue_write (issue_write),
		.issue_read  (issue_read),
		.rd_phase    (rd_phase),
		.byte_addr   (byte_addr),
		.avl_rsp     (avl_rsp),
		.avl_cmd     (avl_cmd),
		.rd_byte     (rd_byte),
		.word_full   (word_full),
		.lanes_empty (lanes_empty),
		.cmd_done    (cmd_done)
	);

endmodule

// File: source/i2c_side_pkg.sv
/*
 * Types for the I2C slave side of the bridge: the strobes and levels
 * coming from the slave core and the byte handed back to its transmitter.
 */

`include "bridge_consts.svh"

package i2c_side_pkg;

	typedef struct packed {
		logic                   rx_valid;   // received byte ready, one cycle
		logic [`I2C_BYTE_W-1:0] rx_byte;    // held until the next byte arrives
		logic                   rd_req;     // master addressed us for a read
		logic                   stop_det;
		logic                   start_det;
		logic                   ack_det;    // level
		logic                   tx_chk_ack; // slave is sampling the master ack
	} i2c_evt_t;

	typedef struct packed {
		logic                   valid; // one-cycle pulse
		logic [`I2C_BYTE_W-1:0] data;
	} rd_byte_t;

endpackage

// File: source/word_addr_gen.sv
/*
 * Word-address capture and byte-address counter. Address bytes shift in
 * msb first; the counter loads from them and then steps once per packed
 * write byte or per read word returned.
 */

`timescale 1ns/1ps

`include "bridge_consts.svh"

module word_addr_gen (
	input  logic                   i2c_clk,
	input  logic                   i2c_rst_n,
	input  logic [`I2C_BYTE_W-1:0] rx_byte,
	input  logic                   addr_shift,
	input  logic                   addr_load,
	input  logic                   pack_byte,
	input  logic                   avl_readdatavalid,
	input  logic                   rd_phase,
	output logic [`BYTE_ADDR_W-1:0] byte_addr
);

	logic [`BYTE_ADDR_W-1:0] addr_sr;
	logic [`BYTE_ADDR_W-1:0] addr_asm;
	logic                    incr;

	// the last address byte shifts on the same edge as the load, so the load
	// takes the shifted value
	assign addr_asm = addr_shift ?
		{addr_sr[`BYTE_ADDR_W-`I2C_BYTE_W-1:0], rx_byte} : addr_sr;

	always_ff @(posedge i2c_clk) begin
		if (addr_shift)
			addr_sr <= addr_asm;
	end

	assign incr = pack_byte | (avl_readdatavalid & rd_phase);

	always_ff @(posedge i2c_clk or negedge i2c_rst_n) begin
		if (!i2c_rst_n)
			byte_addr <= '0;
		else if (addr_load)
			byte_addr <= addr_asm;
		else if (incr)
			byte_addr <= byte_addr + 1'b1; // wraps at the top of the space
	end

	// load only happens between the address and data phases
	a_no_load_incr: assert property (@(posedge i2c_clk) disable iff (!i2c_rst_n)
		!(incr && addr_load));

endmodule

// File: sources.f
+incdir+source
source/i2c_side_pkg.sv
source/avl_side_pkg.sv
source/bridge_fsm.sv
source/word_addr_gen.sv
source/byte_lane_steer.sv
source/i2c_avl_bridge.sv
testbench/tb_i2c_avl_bridge.sv

// File: testbench/tb_i2c_avl_bridge.sv
/*
 * Testbench for the I2C to Avalon-MM bridge. Plays a table of I2C write and
 * read messages, models a 256-word Avalon slave with random waitrequest and
 * checks every accepted command and every byte handed back to the I2C side.
 */

`timescale 1ns/1ps

`include "bridge_consts.svh"

module tb_i2c_avl_bridge
	import i2c_side_pkg::*;
	import avl_side_pkg::*;
();

	localparam int N_ROWS  = 7;
	localparam int RST_CYC = 5;
	localparam int EVT_GAP = 3; // idle clocks after each I2C event

	typedef enum int {EV_BYTE, EV_STOP, EV_START, EV_RD_REQ, EV_ACK} evt_kind_t;

	typedef struct packed {
		logic                    is_read;
		logic [`BYTE_ADDR_W-1:0] addr;
		logic [7:0]              count;
		logic [7:0]              base; // first data byte of a write
	} row_t;

	logic     i2c_clk = 1'b0;
	logic     i2c_rst_n = 1'b0;
	i2c_evt_t i2c_evt = '0;
	avl_rsp_t avl_rsp = '0;
	avl_cmd_t avl_cmd;
	rd_byte_t rd_byte;

	row_t        rows [N_ROWS];
	logic [31:0] mem [256];
	logic [7:0]  shadow [1024]; // byte view of what mem should hold
	avl_cmd_t    exp_cmd_q [$];
	rd_byte_t    exp_rd_q [$];
	avl_cmd_t    held_cmd;
	logic        cmd_held = 1'b0;
	avl_cmd_t    acc_cmd;
	logic        acc_valid = 1'b0;
	logic        rd_pend = 1'b0;
	logic [31:0] rd_pend_addr;
	logic [31:0] rng = 32'd14248;
	int          n_checks = 0;
	int          n_errors = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	initial begin
		forever #20 i2c_clk = ~i2c_clk;
	end

	i2c_avl_bridge i2c_avl_bridge_inst (
		.i2c_clk   (i2c_clk),
		.i2c_rst_n (i2c_rst_n),
		.i2c_evt   (i2c_evt),
		.avl_rsp   (avl_rsp),
		.avl_cmd   (avl_cmd),
		.rd_byte   (rd_byte)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// power-up byte value taken from the full 10-bit byte address
	function automatic logic [7:0] fill_byte(input logic [9:0] a);
		return (a[7:0] * 8'd7) ^ {6'd0, a[9:8]} ^ 8'h3c;
	endfunction

	task automatic check_cmd(input avl_cmd_t got, input avl_cmd_t exp, input string what);
		logic [31:0] mask;
		logic        ok;
		int          b;
		n_checks++;
		for (b = 0; b < `AVL_BE_W; b++)
			mask[b*8 +: 8] = {8{exp.byteenable[b]}};
		ok = (got.read === exp.read) && (got.write === exp.write);
		if (exp.read || exp.write)
			ok = ok && (got.addr === exp.addr) && (got.byteenable === exp.byteenable);
		if (exp.write)
			ok = ok && (((got.writedata ^ exp.writedata) & mask) === '0);
		if (!ok) begin
			n_errors++;
			$display("error %0t: %s, got rd %b wr %b addr %h data %h be %h", $time, what,
				got.read, got.write, got.addr, got.writedata, got.byteenable);
			$display("      expected rd %b wr %b addr %h data %h be %h",
				exp.read, exp.write, exp.addr, exp.writedata, exp.byteenable);
		end
	endtask

	task automatic check_rd_byte(input rd_byte_t got, input rd_byte_t exp, input string what);
		n_checks++;
		if (got.valid !== exp.valid || (exp.valid && got.data !== exp.data)) begin
			n_errors++;
			$display("error %0t: %s, got valid %b data %h, expected valid %b data %h",
				$time, what, got.valid, got.data, exp.valid, exp.data);
		end
	endtask

	task automatic send_evt(input evt_kind_t kind, input logic [7:0] d);
		i2c_evt_t ev;
		i2c_evt_t idle_ev;
		ev = '0;
		ev.rx_byte    = (kind == EV_BYTE) ? d : i2c_evt.rx_byte; // held between bytes
		ev.rx_valid   = (kind == EV_BYTE);
		ev.stop_det   = (kind == EV_STOP);
		ev.start_det  = (kind == EV_START);
		ev.rd_req     = (kind == EV_RD_REQ);
		ev.ack_det    = (kind == EV_ACK);
		ev.tx_chk_ack = (kind == EV_ACK);
		idle_ev = '0;
		idle_ev.rx_byte = ev.rx_byte;
		@(posedge i2c_clk);
		i2c_evt <= ev;
		@(posedge i2c_clk);
		i2c_evt <= idle_ev;
		repeat (EVT_GAP) @(posedge i2c_clk);
	endtask

	// the I2C side stretches the clock until every expected response is seen
	task automatic wait_drain();
		while (exp_cmd_q.size() != 0 || exp_rd_q.size() != 0)
			@(posedge i2c_clk);
	endtask

	task automatic run_row(input row_t row);
		logic [`BYTE_ADDR_W-1:0] a;
		logic [7:0]              d;
		avl_cmd_t                wc;
		avl_cmd_t                rc;
		rd_byte_t                rb;
		int                      i;
		wc = '0;
		wc.write = 1'b1;
		send_evt(EV_BYTE, row.addr[15:8]);
		send_evt(EV_BYTE, row.addr[7:0]);
		if (!row.is_read) begin
			for (i = 0; i < int'(row.count); i++) begin
				a = row.addr + 16'(i);
				d = row.base + 8'(i);
				if (wc.byteenable == '0)
					wc.addr = {16'h0, a[15:2], 2'b00};
				wc.writedata[a[1:0]*8 +: 8] = d;
				wc.byteenable[a[1:0]] = 1'b1;
				shadow[a[9:0]] = d;
				if (a[1:0] == 2'd3) begin
					exp_cmd_q.push_back(wc); // lane 3 filled
					wc.byteenable = '0;
				end
				send_evt(EV_BYTE, d);
				wait_drain();
			end
			if (wc.byteenable != '0)
				exp_cmd_q.push_back(wc);
			send_evt(EV_STOP, 8'h00);
			wait_drain();
		end else begin
			send_evt(EV_START, 8'h00);
			for (i = 0; i < int'(row.count); i++) begin
				a = row.addr + 16'(i);
				rc = '0;
				rc.read = 1'b1;
				rc.addr = {16'h0, a[15:2], 2'b00};
				rc.byteenable = 4'hf;
				rb.valid = 1'b1;
				rb.data = shadow[a[9:0]];
				exp_cmd_q.push_back(rc);
				exp_rd_q.push_back(rb);
				send_evt((i == 0) ? EV_RD_REQ : EV_ACK, 8'h00);
				wait_drain();
			end
			send_evt(EV_STOP, 8'h00);
		end
	endtask

	// DUT outputs and waitrequest are settled by the falling edge
	always @(negedge i2c_clk) begin
		acc_valid = 1'b0;
		if (i2c_rst_n) begin
			if (cmd_held)
				check_cmd(avl_cmd, held_cmd, "command changed while waitrequest high");
			if ((avl_cmd.read || avl_cmd.write) && !avl_rsp.waitrequest) begin
				acc_valid = 1'b1;
				acc_cmd = avl_cmd;
				if (exp_cmd_q.size() == 0) begin
					n_errors++;
					$display("Avalon command accepted at %0t when none was due", $time);
				end else
					check_cmd(avl_cmd, exp_cmd_q.pop_front(), "accepted command");
			end
			cmd_held = (avl_cmd.read || avl_cmd.write) && avl_rsp.waitrequest;
			held_cmd = avl_cmd;
			if (rd_byte.valid) begin
				if (exp_rd_q.size() == 0) begin
					n_errors++;
					$display("read byte returned at %0t when none was requested", $time);
				end else
					check_rd_byte(rd_byte, exp_rd_q.pop_front(), "read byte");
			end
		end
	end

	// Avalon slave model serving the commands accepted at the falling edge
	always @(posedge i2c_clk) begin
		logic [31:0] w;
		int          b;
		rng = xorshift(rng);
		avl_rsp.waitrequest   <= (rng[1:0] == 2'd0);
		rd_pend               <= acc_valid && acc_cmd.read;
		rd_pend_addr          <= acc_cmd.addr;
		avl_rsp.readdatavalid <= rd_pend; // two edges after acceptance
		if (rd_pend)
			avl_rsp.readdata <= mem[rd_pend_addr[9:2]];
		if (acc_valid && acc_cmd.write) begin
			w = mem[acc_cmd.addr[9:2]];
			for (b = 0; b < `AVL_BE_W; b++)
				if (acc_cmd.byteenable[b])
					w[b*8 +: 8] = acc_cmd.writedata[b*8 +: 8];
			mem[acc_cmd.addr[9:2]] = w;
		end
	end

	always @(posedge i2c_clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout, DUT gave no response within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int r;
		int errs_before;
		int rows_ok;
		rows_ok = 0;
		rows[0] = '{is_read: 1'b0, addr: 16'h0010, count: 8'd4, base: 8'h10};
		rows[1] = '{is_read: 1'b0, addr: 16'h0020, count: 8'd3, base: 8'h40};
		rows[2] = '{is_read: 1'b0, addr: 16'h0035, count: 8'd2, base: 8'h60};
		rows[3] = '{is_read: 1'b0, addr: 16'h0041, count: 8'd7, base: 8'h80};
		rows[4] = '{is_read: 1'b1, addr: 16'h0042, count: 8'd5, base: 8'h00};
		rows[5] = '{is_read: 1'b1, addr: 16'h0100, count: 8'd3, base: 8'h00};
		rows[6] = '{is_read: 1'b1, addr: 16'h0011, count: 8'd2, base: 8'h00};
		for (r = 0; r < 256; r++)
			mem[r] = {fill_byte(10'(4*r+3)), fill_byte(10'(4*r+2)),
				fill_byte(10'(4*r+1)), fill_byte(10'(4*r))};
		for (r = 0; r < 1024; r++)
			shadow[r] = fill_byte(10'(r));
		cycle_limit = RST_CYC + 10;
		for (r = 0; r < N_ROWS; r++)
			cycle_limit += (int'(rows[r].count) + 4) * 20;
		repeat (RST_CYC) @(posedge i2c_clk);
		i2c_rst_n <= 1'b1;
		repeat (3) begin
			@(negedge i2c_clk);
			check_cmd(avl_cmd, '0, "bus idle after reset");
			check_rd_byte(rd_byte, '0, "no read byte after reset");
		end
		for (r = 0; r < N_ROWS; r++) begin
			errs_before = n_errors;
			run_row(rows[r]);
			if (n_errors == errs_before)
				rows_ok++;
			$display("row %0d %s addr %h bytes %0d: %s", r, rows[r].is_read ? "read " : "write",
				rows[r].addr, rows[r].count, (n_errors == errs_before) ? "ok" : "mismatch");
		end
		$display("rows ok %0d of %0d, checks %0d, errors %0d",
			rows_ok, N_ROWS, n_checks, n_errors);
		if (n_errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
